// File: trivium_cfg.svh
`ifndef TRIVIUM_CFG_SVH
`define TRIVIUM_CFG_SVH

// --------------------
// trivium sizes
// --------------------

// full internal state, three shift registers 93 + 84 + 111
`define TRIV_STATE_BITS 288

// secret key length
`define TRIV_KEY_BITS 80

// initialisation vector length
`define TRIV_IV_BITS 80

// --------------------
// stepping
// --------------------

// rounds unrolled into one evaluate cycle
// also the width of one keystream word
`define TRIV_STEP_BITS 16

// rounds discarded after loading, 4 x 288
`define TRIV_WARMUP_ROUNDS 1152

// evaluate cycles spent in warm-up
`define TRIV_WARMUP_STEPS (`TRIV_WARMUP_ROUNDS / `TRIV_STEP_BITS)

`endif

// File: drp_pkg.sv
`default_nettype none

package drp_pkg;

	// --------------------
	// encoding
	// --------------------

	// precharge = spacer, evaluate = data on the rails
	typedef enum logic {
		PH_PRECHARGE = 1'b0,
		PH_EVALUATE  = 1'b1
	} drp_phase_t;

	// one logical bit on two rails
	// valid data is t != f, spacer is both low
	typedef struct packed {
		logic t;
		logic f;
	} drp_bit_t;

	// --------------------
	// gates
	// --------------------

	// true rail is the single product, false rail takes the other three minterms
	function automatic drp_bit_t drp_and(input drp_bit_t a, input drp_bit_t b);
		drp_bit_t z;
		z.t = a.t & b.t;
		z.f = (a.t & b.f) | (a.f & b.t) | (a.f & b.f);
		return z;
	endfunction

	// both rails are two minterms, so the gate stays balanced
	function automatic drp_bit_t drp_xor(input drp_bit_t a, input drp_bit_t b);
		drp_bit_t z;
		z.t = (a.t & b.f) | (a.f & b.t);
		z.f = (a.t & b.t) | (a.f & b.f);
		return z;
	endfunction

endpackage

`default_nettype wire

// File: trivium_pkg.sv
`default_nettype none

package trivium_pkg;

	`include "trivium_cfg.svh"

	// --------------------
	// rail vectors
	// --------------------

	// one rail of the full state
	typedef logic [`TRIV_STATE_BITS-1:0] triv_rail_t;

	// one rail of key and IV side by side, for the checker
	typedef logic [`TRIV_KEY_BITS+`TRIV_IV_BITS-1:0] triv_kiv_t;

	// --------------------
	// structs
	// --------------------

	// dual-rail state, index 0 is s1 of the cipher spec
	typedef struct packed {
		triv_rail_t t;
		triv_rail_t f;
	} triv_state_t;

	// load command from the host
	// key bit i lands in s(i+1), IV bit i in s(i+94)
	typedef struct packed {
		logic [`TRIV_KEY_BITS-1:0] key_t;
		logic [`TRIV_KEY_BITS-1:0] key_f;
		logic [`TRIV_IV_BITS-1:0]  iv_t;
		logic [`TRIV_IV_BITS-1:0]  iv_f;
	} triv_load_t;

	// keystream word, bit 0 is the earliest round
	typedef struct packed {
		logic [`TRIV_STEP_BITS-1:0] t;
		logic [`TRIV_STEP_BITS-1:0] f;
	} triv_word_t;

	// both rails low
	localparam triv_word_t TRIV_SPACER = '0;

	// dual-rail zero in every position, true rail low and false rail high
	localparam triv_state_t TRIV_STATE_ZERO = '{t: '0, f: '1};

endpackage

`default_nettype wire

// File: drp_phase_gen.sv
`timescale 1ns/10ps
`default_nettype none

// two-phase sequencer for the dual-rail datapath
// one cycle of precharge, one of evaluate, forever
module drp_phase_gen (
	input  logic                CLK,
	input  logic                rst,
	output drp_pkg::drp_phase_t phase
);

	import drp_pkg::*;

	// --------------------
	// sequencer
	// --------------------

	always_ff @(posedge CLK) begin
		if (rst) begin
			// start in precharge so the first data cycle sees settled spacers
			phase <= PH_PRECHARGE;
		end else begin
			case (phase)
				PH_PRECHARGE: begin
					phase <= PH_EVALUATE;
				end
				PH_EVALUATE: begin
					phase <= PH_PRECHARGE;
				end
				default: begin
					phase <= PH_PRECHARGE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: drp_rail_checker.sv
`timescale 1ns/10ps
`default_nettype none

// complementarity check on a bundle of rail pairs
// flags any position where true and false rails agree
module drp_rail_checker #(
	parameter type rail_t = logic [0:0]
) (
	input  logic                CLK,
	input  logic                rst,
	input  drp_pkg::drp_phase_t phase,
	input  rail_t               rails_t,
	input  rail_t               rails_f,
	output logic                err
);

	import drp_pkg::*;

	// one bit per pair, high where the pair is 11 or 00
	rail_t bad_pairs;

	// any bad pair in this bundle
	logic  any_bad;

	// --------------------
	// compare
	// --------------------

	// xnor per position
	assign bad_pairs = ~(rails_t ^ rails_f);
	assign any_bad   = |bad_pairs;

	// --------------------
	// flag
	// --------------------

	// only evaluate cycles carry data
	// a precharge cycle keeps the last verdict
	always_ff @(posedge CLK) begin
		if (rst) begin
			err <= 1'b0;
		end else if (phase == PH_EVALUATE) begin
			err <= any_bad;
		end
	end

endmodule

`default_nettype wire

// File: drp_trivium_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "trivium_cfg.svh"

// dual-rail trivium datapath and its sequencing
module drp_trivium_core (
	input  logic                    CLK,
	input  logic                    rst,
	input  drp_pkg::drp_phase_t     phase,
	input  logic                    load_req,
	input  trivium_pkg::triv_load_t load,
	input  logic                    word_req,
	input  logic                    ack_clear,
	output trivium_pkg::triv_word_t step_word,
	output logic                    load_done,
	output logic                    word_done,
	output logic                    rail_err
);

	import drp_pkg::*;
	import trivium_pkg::*;

	// zero fill above the IV and between key and IV
	localparam int PAD_HI = `TRIV_STATE_BITS - 3 - `TRIV_IV_BITS - 93;
	localparam int PAD_LO = 93 - `TRIV_KEY_BITS;
	localparam int WARM_W = $clog2(`TRIV_WARMUP_STEPS);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WARM,
		ST_READY,
		ST_WAIT
	} ctrl_t;

	ctrl_t              ctrl_q;
	logic [WARM_W-1:0]  warm_cnt;
	logic               eval;
	triv_state_t        state_q;
	triv_state_t        init_state;
	triv_state_t        step_next;
	triv_word_t         step_bits;
	triv_load_t         load_q;
	logic               kiv_err;
	logic               st_err;

	// single pair out of the state
	function automatic drp_bit_t tap(input triv_state_t s, input int idx);
		drp_bit_t b;
		b.t = s.t[idx];
		b.f = s.f[idx];
		return b;
	endfunction

	assign eval = (phase == PH_EVALUATE);

	// --------------------
	// load mapping
	// --------------------

	// s286..s288 set, rest of the padding clear, complements on the false rail
	assign init_state.t = {3'b111, {PAD_HI{1'b0}}, load.iv_t, {PAD_LO{1'b0}}, load.key_t};
	assign init_state.f = {3'b000, {PAD_HI{1'b1}}, load.iv_f, {PAD_LO{1'b1}}, load.key_f};

	// --------------------
	// round logic
	// --------------------

	// TRIV_STEP_BITS rounds chained in one evaluate cycle
	always_comb begin
		triv_state_t s;
		drp_bit_t    t1;
		drp_bit_t    t2;
		drp_bit_t    t3;
		drp_bit_t    z;
		s = state_q;
		step_bits = '0;
		for (int r = 0; r < `TRIV_STEP_BITS; r++) begin
			// linear taps s66+s93, s162+s177, s243+s288
			t1 = drp_xor(tap(s, 65), tap(s, 92));
			t2 = drp_xor(tap(s, 161), tap(s, 176));
			t3 = drp_xor(tap(s, 242), tap(s, 287));
			// output bit before the nonlinear terms
			z = drp_xor(drp_xor(t1, t2), t3);
			step_bits.t[r] = z.t;
			step_bits.f[r] = z.f;
			// feedback with the and terms
			t1 = drp_xor(drp_xor(t1, drp_and(tap(s, 90), tap(s, 91))), tap(s, 170));
			t2 = drp_xor(drp_xor(t2, drp_and(tap(s, 174), tap(s, 175))), tap(s, 263));
			t3 = drp_xor(drp_xor(t3, drp_and(tap(s, 285), tap(s, 286))), tap(s, 68));
			// shift all three registers by one
			s.t = {s.t[286:177], t2.t, s.t[175:93], t1.t, s.t[91:0], t3.t};
			s.f = {s.f[286:177], t2.f, s.f[175:93], t1.f, s.f[91:0], t3.f};
		end
		step_next = s;
	end

	// --------------------
	// control
	// --------------------

	always_ff @(posedge CLK) begin
		if (rst) begin
			ctrl_q    <= ST_IDLE;
			warm_cnt  <= '0;
			load_done <= 1'b0;
			word_done <= 1'b0;
			state_q   <= TRIV_STATE_ZERO;
			load_q    <= '{key_t: '0, key_f: '1, iv_t: '0, iv_f: '1};
		end else begin
			load_done <= 1'b0;
			word_done <= 1'b0;
			case (ctrl_q)
				ST_IDLE, ST_READY: begin
					// a load wins over a word, words need a loaded state
					if (eval && load_req) begin
						load_q   <= load;
						state_q  <= init_state;
						warm_cnt <= '0;
						ctrl_q   <= ST_WARM;
					end else if (eval && word_req && ctrl_q == ST_READY) begin
						state_q   <= step_next;
						word_done <= 1'b1;
						ctrl_q    <= ST_WAIT;
					end
				end
				ST_WARM: begin
					if (eval) begin
						state_q <= step_next;
						if (warm_cnt == WARM_W'(`TRIV_WARMUP_STEPS - 1)) begin
							load_done <= 1'b1;
							ctrl_q    <= ST_WAIT;
						end else begin
							warm_cnt <= warm_cnt + 1'b1;
						end
					end
				end
				ST_WAIT: begin
					// hold state until the host has closed the handshake
					if (ack_clear) begin
						ctrl_q <= ST_READY;
					end
				end
				default: begin
					ctrl_q <= ST_IDLE;
				end
			endcase
		end
	end

	// keystream bits of the word step, held through back-pressure
	always_ff @(posedge CLK) begin
		if (eval && word_req && ctrl_q == ST_READY && !load_req) begin
			step_word <= step_bits;
		end
	end

	// --------------------
	// rail checks
	// --------------------

	drp_rail_checker #(
		.rail_t (triv_kiv_t)
	) u_kiv_chk (
		.CLK     (CLK),
		.rst     (rst),
		.phase   (phase),
		.rails_t ({load_q.key_t, load_q.iv_t}),
		.rails_f ({load_q.key_f, load_q.iv_f}),
		.err     (kiv_err)
	);

	drp_rail_checker #(
		.rail_t (triv_rail_t)
	) u_state_chk (
		.CLK     (CLK),
		.rst     (rst),
		.phase   (phase),
		.rails_t (state_q.t),
		.rails_f (state_q.f),
		.err     (st_err)
	);

	assign rail_err = kiv_err | st_err;

endmodule

`default_nettype wire

// File: drp_output_stage.sv
`timescale 1ns/10ps
`default_nettype none

// host side of both handshakes plus the fault latch
module drp_output_stage (
	input  logic                    CLK,
	input  logic                    rst,
	input  drp_pkg::drp_phase_t     phase,
	input  trivium_pkg::triv_word_t step_word,
	input  logic                    load_done,
	input  logic                    word_done,
	input  logic                    rail_err,
	input  logic                    load_req,
	input  logic                    word_req,
	output logic                    load_ack,
	output logic                    word_ack,
	output logic                    ack_clear,
	output trivium_pkg::triv_word_t word,
	output logic                    fault
);

	import drp_pkg::*;
	import trivium_pkg::*;

	// --------------------
	// handshakes
	// --------------------

	// ack follows the done pulse by one cycle
	// ack drops once the host lets go, and the core is told it may go on
	always_ff @(posedge CLK) begin
		if (rst) begin
			load_ack  <= 1'b0;
			word_ack  <= 1'b0;
			ack_clear <= 1'b0;
		end else begin
			ack_clear <= 1'b0;
			if (load_done) begin
				load_ack <= 1'b1;
			end else if (load_ack && !load_req) begin
				load_ack  <= 1'b0;
				ack_clear <= 1'b1;
			end
			if (word_done) begin
				word_ack <= 1'b1;
			end else if (word_ack && !word_req) begin
				word_ack  <= 1'b0;
				ack_clear <= 1'b1;
			end
		end
	end

	// --------------------
	// fault
	// --------------------

	// checker flags move on evaluate edges
	// take them in the precharge cycle right after
	always_ff @(posedge CLK) begin
		if (rst) begin
			fault <= 1'b0;
		end else if (phase == PH_PRECHARGE && rail_err) begin
			fault <= 1'b1;
		end
	end

	// keystream only inside an open word handshake on a clean device
	assign word = (word_ack && !fault) ? step_word : TRIV_SPACER;

endmodule

`default_nettype wire

// File: drp_trivium_top.sv
`timescale 1ns/10ps
`default_nettype none

// dual-rail trivium keystream generator
module drp_trivium_top (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    load_req,
	input  trivium_pkg::triv_load_t load,
	output logic                    load_ack,
	input  logic                    word_req,
	output logic                    word_ack,
	output trivium_pkg::triv_word_t word,
	output logic                    fault
);

	import drp_pkg::*;
	import trivium_pkg::*;

	drp_phase_t phase;
	triv_word_t step_word;
	logic       load_done;
	logic       word_done;
	logic       rail_err;
	logic       ack_clear;

	// --------------------
	// phase
	// --------------------

	drp_phase_gen u_phase (
		.CLK   (CLK),
		.rst   (rst),
		.phase (phase)
	);

	// --------------------
	// cipher
	// --------------------

	drp_trivium_core u_core (
		.CLK       (CLK),
		.rst       (rst),
		.phase     (phase),
		.load_req  (load_req),
		.load      (load),
		.word_req  (word_req),
		.ack_clear (ack_clear),
		.step_word (step_word),
		.load_done (load_done),
		.word_done (word_done),
		.rail_err  (rail_err)
	);

	// --------------------
	// host side
	// --------------------

	drp_output_stage u_out (
		.CLK       (CLK),
		.rst       (rst),
		.phase     (phase),
		.step_word (step_word),
		.load_done (load_done),
		.word_done (word_done),
		.rail_err  (rail_err),
		.load_req  (load_req),
		.word_req  (word_req),
		.load_ack  (load_ack),
		.word_ack  (word_ack),
		.ack_clear (ack_clear),
		.word      (word),
		.fault     (fault)
	);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

// clock and reset source for the testbench
// reset_req seen high at a rising edge restarts the reset window
module tb_clock_gen (
	input  logic reset_req,
	output logic CLK,
	output logic rst
);

	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 5;

	// rising edges left with rst high
	int rst_left;

	// 20 ns period
	initial begin
		CLK = 1'b0;
		forever begin
			#HALF_PERIOD CLK = ~CLK;
		end
	end

	// power-on reset
	initial begin
		rst      = 1'b1;
		rst_left = RESET_CYCLES;
	end

	always @(posedge CLK) begin
		if (reset_req) begin
			rst      <= 1'b1;
			rst_left <= RESET_CYCLES;
		end else if (rst_left > 0) begin
			rst_left <= rst_left - 1;
			// last edge the DUT still sees rst high
			if (rst_left == 1) begin
				rst <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_trivium_model.svh
`ifndef TB_TRIVIUM_MODEL_SVH
`define TB_TRIVIUM_MODEL_SVH

	// --------------------
	// single-rail trivium
	// --------------------

	// index 0 holds s1 of the cipher spec
	logic [`TRIV_STATE_BITS-1:0] ref_state;

	// spec numbering, s1 to s288
	function automatic logic spec_bit(input int i);
		return ref_state[i-1];
	endfunction

	// one round of the spec, z is the output bit
	task automatic clock_round(output logic z);
		logic t1;
		logic t2;
		logic t3;
		t1 = spec_bit(66) ^ spec_bit(93);
		t2 = spec_bit(162) ^ spec_bit(177);
		t3 = spec_bit(243) ^ spec_bit(288);
		z  = t1 ^ t2 ^ t3;
		t1 = t1 ^ (spec_bit(91) & spec_bit(92)) ^ spec_bit(171);
		t2 = t2 ^ (spec_bit(175) & spec_bit(176)) ^ spec_bit(264);
		t3 = t3 ^ (spec_bit(286) & spec_bit(287)) ^ spec_bit(69);
		// all three registers move up by one, feedback enters at s1, s94, s178
		ref_state      = {ref_state[`TRIV_STATE_BITS-2:0], 1'b0};
		ref_state[0]   = t3;
		ref_state[93]  = t1;
		ref_state[177] = t2;
	endtask

	// key in s1.., IV in s94.., s286..s288 set, then the warm-up rounds
	task automatic init_keystream(input logic [`TRIV_KEY_BITS-1:0] key,
	                              input logic [`TRIV_IV_BITS-1:0] iv);
		logic z;
		ref_state = '0;
		ref_state[`TRIV_KEY_BITS-1:0]   = key;
		ref_state[92+`TRIV_IV_BITS:93]  = iv;
		ref_state[287:285]              = 3'b111;
		for (int r = 0; r < `TRIV_WARMUP_ROUNDS; r++) begin
			clock_round(z);
		end
	endtask

	// bit 0 is the earliest round
	task automatic next_keystream_word(output logic [`TRIV_STEP_BITS-1:0] w);
		logic z;
		for (int r = 0; r < `TRIV_STEP_BITS; r++) begin
			clock_round(z);
			w[r] = z;
		end
	endtask

`endif

// File: tb_drp_trivium.sv
`timescale 1ns/10ps
`default_nettype none
`include "trivium_cfg.svh"

// table-driven testbench for the dual-rail trivium generator
module tb_drp_trivium;

	import trivium_pkg::*;

	localparam int TIMEOUT = 400;
	localparam int N_TESTS = 6;
	localparam int KEY_W   = `TRIV_KEY_BITS;
	localparam int IV_W    = `TRIV_IV_BITS;

	// one table row
	// mask bits set the false rail equal to the true rail
	typedef struct packed {
		logic [KEY_W-1:0]      key;
		logic [IV_W-1:0]       iv;
		logic [KEY_W+IV_W-1:0] mask;
		logic [7:0]            n_words;
		logic                  exp_fault;
	} entry_t;

	logic       CLK;
	logic       rst;
	logic       reset_req;
	logic       load_req;
	triv_load_t load;
	logic       load_ack;
	logic       word_req;
	logic       word_ack;
	triv_word_t word;
	logic       fault;

	entry_t     vectors [N_TESTS];
	int         err_cnt;
	int         fail_tests;

	`include "tb_trivium_model.svh"

	tb_clock_gen u_clk (
		.reset_req (reset_req),
		.CLK       (CLK),
		.rst       (rst)
	);

	drp_trivium_top dut (
		.CLK      (CLK),
		.rst      (rst),
		.load_req (load_req),
		.load     (load),
		.load_ack (load_ack),
		.word_req (word_req),
		.word_ack (word_ack),
		.word     (word),
		.fault    (fault)
	);

	// --------------------
	// helpers
	// --------------------

	// drive and sample 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic flag_mismatch(input string name, input logic [31:0] exp,
	                             input logic [31:0] got);
		$display("** Error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
		err_cnt++;
	endtask

	task automatic note_failure(input string what);
		$display("failure at %0t: %s", $time, what);
		err_cnt++;
	endtask

	function automatic logic [79:0] draw_random_80();
		logic [95:0] r;
		r = {$urandom(), $urandom(), $urandom()};
		return r[79:0];
	endfunction

	task automatic set_entry(input int i, input logic [KEY_W-1:0] key,
	                         input logic [IV_W-1:0] iv, input logic [KEY_W+IV_W-1:0] mask,
	                         input int n, input logic f);
		vectors[i].key       = key;
		vectors[i].iv        = iv;
		vectors[i].mask      = mask;
		vectors[i].n_words   = n[7:0];
		vectors[i].exp_fault = f;
	endtask

	// restart the reset window, wait for release, check the idle outputs
	task automatic apply_reset();
		int n;
		next_cycle();
		reset_req = 1'b1;
		next_cycle();
		reset_req = 1'b0;
		n = 0;
		while (rst && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (rst) begin
			note_failure("reset never released");
		end
		if (load_ack !== 1'b0) begin
			flag_mismatch("load_ack", 32'h0, load_ack);
		end
		if (word_ack !== 1'b0) begin
			flag_mismatch("word_ack", 32'h0, word_ack);
		end
		if (fault !== 1'b0) begin
			flag_mismatch("fault", 32'h0, fault);
		end
		if (word !== TRIV_SPACER) begin
			flag_mismatch("word", TRIV_SPACER, word);
		end
	endtask

	// four-phase load with the payload held through the whole handshake
	task automatic load_key_iv(input entry_t e);
		int n;
		load.key_t = e.key;
		load.key_f = ~e.key ^ e.mask[KEY_W+IV_W-1:IV_W];
		load.iv_t  = e.iv;
		load.iv_f  = ~e.iv ^ e.mask[IV_W-1:0];
		load_req   = 1'b1;
		n = 0;
		while (!load_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!load_ack) begin
			note_failure("load_ack did not rise within the timeout");
		end
		// a corrupt rail pair is flagged long before warm-up ends
		if (fault !== e.exp_fault) begin
			flag_mismatch("fault", e.exp_fault, fault);
		end
		load_req = 1'b0;
		n = 0;
		while (load_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (load_ack) begin
			note_failure("load_ack stayed high after load_req fell");
		end
	endtask

	// one word handshake with the request held for hold extra cycles
	task automatic fetch_word(input logic [15:0] ks, input int hold, input logic exp_fault);
		triv_word_t exp_w;
		int         n;
		// faulty device hands out spacers only
		exp_w    = exp_fault ? TRIV_SPACER : {ks, ~ks};
		word_req = 1'b1;
		n = 0;
		while (!word_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!word_ack) begin
			note_failure("word_ack did not rise within the timeout");
		end else begin
			if (word !== exp_w) begin
				flag_mismatch("word", exp_w, word);
			end
			// back-pressure keeps ack and word frozen
			for (int h = 0; h < hold; h++) begin
				next_cycle();
				if (word_ack !== 1'b1) begin
					flag_mismatch("word_ack", 32'h1, word_ack);
				end
				if (word !== exp_w) begin
					flag_mismatch("word", exp_w, word);
				end
			end
		end
		word_req = 1'b0;
		n = 0;
		while (word_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (word_ack) begin
			note_failure("word_ack stayed high after word_req fell");
		end
		if (word !== TRIV_SPACER) begin
			flag_mismatch("word", TRIV_SPACER, word);
		end
	endtask

	// the unloaded core must leave the request unanswered for the whole window
	task automatic probe_early_word();
		int   n;
		logic seen;
		seen     = 1'b0;
		word_req = 1'b1;
		n = 0;
		while (n < TIMEOUT) begin
			next_cycle();
			n++;
			if (word_ack) begin
				seen = 1'b1;
			end
		end
		word_req = 1'b0;
		if (seen) begin
			note_failure("word_ack answered a word_req before any load");
		end
	endtask

	task automatic finish_test(input int idx, input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			$display("test %0d (%s): ok", idx, name);
		end else begin
			$display("test %0d (%s): %0d errors", idx, name, err_cnt - errs_before);
			fail_tests++;
		end
	endtask

	// --------------------
	// main sequence
	// --------------------

	initial begin
		logic [15:0] ks;
		int          errs_before;
		void'($urandom(32'ha97df82a));
		reset_req  = 1'b0;
		load_req   = 1'b0;
		word_req   = 1'b0;
		load       = '0;
		err_cnt    = 0;
		fail_tests = 0;

		// zero vector, a fixed one, random ones
		// row 3 turns key bit 17 into 00, row 4 turns IV bit 40 into 11
		set_entry(0, '0, '0, '0, 4, 1'b0);
		set_entry(1, 80'h0053a6f94c9ff24598eb, 80'h0d74db42a91077de45ac, '0, 6, 1'b0);
		set_entry(2, draw_random_80(), draw_random_80(), '0, 8, 1'b0);
		set_entry(3, '0, draw_random_80(), 160'd1 << (IV_W + 17), 3, 1'b1);
		set_entry(4, draw_random_80(), '1, 160'd1 << 40, 3, 1'b1);
		set_entry(5, draw_random_80(), draw_random_80(), '0, 5, 1'b0);

		errs_before = err_cnt;
		apply_reset();
		finish_test(0, "reset state", errs_before);

		errs_before = err_cnt;
		apply_reset();
		probe_early_word();
		finish_test(1, "word before load", errs_before);

		for (int i = 0; i < N_TESTS; i++) begin
			errs_before = err_cnt;
			apply_reset();
			load_key_iv(vectors[i]);
			init_keystream(vectors[i].key, vectors[i].iv);
			for (int w = 0; w < vectors[i].n_words; w++) begin
				next_keystream_word(ks);
				// odd words held for a few extra cycles
				fetch_word(ks, (w % 2 == 1) ? 4 : 0, vectors[i].exp_fault);
			end
			if (fault !== vectors[i].exp_fault) begin
				flag_mismatch("fault", vectors[i].exp_fault, fault);
			end
			finish_test(i + 2, "table entry", errs_before);
		end

		$display("tests run: %0d, tests with errors: %0d, errors: %0d",
		         N_TESTS + 2, fail_tests, err_cnt);
		if (err_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
drp_pkg.sv
trivium_pkg.sv
drp_phase_gen.sv
drp_rail_checker.sv
drp_trivium_core.sv
drp_output_stage.sv
drp_trivium_top.sv
tb_clock_gen.sv
tb_drp_trivium.sv
